// ==== aluExecute.sv ====
`default_nettype none

module aluExecute (
  input  wire mipsPkg::aluOpT AluOp,
  input  wire                 AluSrcImm,
  input  wire [31:0]          OperandA,
  input  wire [31:0]          OperandB,
  input  wire [4:0]           Shamt,
  input  wire [31:0]          Imm,
  input  wire [31:0]          PcPlus4Ex,
  input  wire                 Branch,
  input  wire                 BranchNe,
  output logic [31:0]         AluResult,
  output logic                Zero,
  output logic [31:0]         BranchTarget,
  output logic                BranchTaken
);

  logic [31:0] aluB;

  assign aluB = AluSrcImm ? Imm : OperandB;

  always_comb begin
    case (AluOp)
      mipsPkg::AluAdd:  AluResult = OperandA + aluB;
      mipsPkg::AluSub:  AluResult = OperandA - aluB;
      mipsPkg::AluAnd:  AluResult = OperandA & aluB;
      mipsPkg::AluOr:   AluResult = OperandA | aluB;
      mipsPkg::AluXor:  AluResult = OperandA ^ aluB;
      mipsPkg::AluSlt:  AluResult = {31'd0, $signed(OperandA) < $signed(aluB)};
      mipsPkg::AluSltu: AluResult = {31'd0, OperandA < aluB};
      // shifts act on rt
      mipsPkg::AluSll:  AluResult = aluB << Shamt;
      mipsPkg::AluSrl:  AluResult = aluB >> Shamt;
      mipsPkg::AluLui:  AluResult = {aluB[15:0], 16'd0};
      default:          AluResult = '0;
    endcase
  end

  assign Zero = (AluResult == 32'd0);

  // word offset relative to the delay slot
  assign BranchTarget = PcPlus4Ex + {Imm[29:0], 2'b00};

  // bne flips the sense of the equality test
  assign BranchTaken = Branch && (Zero ^ BranchNe);

endmodule

`default_nettype wire

// ==== controlDecoder.sv ====
`default_nettype none

module controlDecoder (
  input  wire                    Clk,
  input  wire                    Reset,
  input  wire                    InstrValid,
  input  wire [31:0]             Instr,
  input  wire [31:0]             RsValue,
  input  wire [31:0]             RtValue,
  input  wire [31:0]             PcPlus4,
  output mipsPkg::aluOpT         AluOp,
  output logic                   AluSrcImm,
  output logic                   MemRead,
  output logic                   MemWrite,
  output mipsPkg::memSizeT       MemSize,
  output logic                   MemUnsigned,
  output logic                   Branch,
  output logic                   BranchNe,
  output logic                   RegWrite,
  output mipsPkg::wbSrcT         WbSrc,
  output logic [31:0]            OperandA,
  output logic [31:0]            OperandB,
  output logic [4:0]             Shamt,
  output logic [31:0]            Imm,
  output logic [31:0]            StoreData,
  output logic [31:0]            PcPlus4Ex,
  output logic [4:0]             WriteReg
);

  mipsPkg::opcodeT  opcode;
  mipsPkg::functT   funct;
  mipsPkg::memSizeT accessSize;
  logic             immZeroExt;
  logic [31:0]      immNext;

  mipsPkg::aluOpT   aluOpNext;
  mipsPkg::memSizeT memSizeNext;
  mipsPkg::wbSrcT   wbSrcNext;
  logic             aluSrcImmNext;
  logic             memReadNext;
  logic             memWriteNext;
  logic             memUnsignedNext;
  logic             branchNext;
  logic             branchNeNext;
  logic             regWriteNext;
  logic [4:0]       writeRegNext;

  assign opcode = mipsPkg::opcodeT'(Instr[31:26]);
  assign funct  = mipsPkg::functT'(Instr[5:0]);

  // logical immediates are zero-extended
  assign immZeroExt = (opcode == mipsPkg::OpAndi) || (opcode == mipsPkg::OpOri);
  assign immNext    = immZeroExt ? {16'd0, Instr[15:0]} : {{16{Instr[15]}}, Instr[15:0]};

  // access size sits in the low opcode bits of loads and stores
  always_comb begin
    if (Instr[27]) begin
      accessSize = mipsPkg::MemWord;
    end else if (Instr[26]) begin
      accessSize = mipsPkg::MemHalf;
    end else begin
      accessSize = mipsPkg::MemByte;
    end
  end

  always_comb begin
    // bubble unless a known instruction says otherwise
    aluOpNext       = mipsPkg::AluAdd;
    aluSrcImmNext   = 1'b0;
    memReadNext     = 1'b0;
    memWriteNext    = 1'b0;
    memSizeNext     = mipsPkg::MemWord;
    memUnsignedNext = 1'b0;
    branchNext      = 1'b0;
    branchNeNext    = 1'b0;
    regWriteNext    = 1'b0;
    wbSrcNext       = mipsPkg::WbAlu;
    writeRegNext    = Instr[20:16];
    if (InstrValid) begin
      case (opcode)
        mipsPkg::OpSpecial: begin
          writeRegNext = Instr[15:11];
          regWriteNext = 1'b1;
          case (funct)
            mipsPkg::FnAddu: aluOpNext = mipsPkg::AluAdd;
            mipsPkg::FnSubu: aluOpNext = mipsPkg::AluSub;
            mipsPkg::FnAnd:  aluOpNext = mipsPkg::AluAnd;
            mipsPkg::FnOr:   aluOpNext = mipsPkg::AluOr;
            mipsPkg::FnXor:  aluOpNext = mipsPkg::AluXor;
            mipsPkg::FnSlt:  aluOpNext = mipsPkg::AluSlt;
            mipsPkg::FnSltu: aluOpNext = mipsPkg::AluSltu;
            mipsPkg::FnSll:  aluOpNext = mipsPkg::AluSll;
            mipsPkg::FnSrl:  aluOpNext = mipsPkg::AluSrl;
            default:         regWriteNext = 1'b0;
          endcase
        end
        mipsPkg::OpAddiu, mipsPkg::OpSlti, mipsPkg::OpAndi, mipsPkg::OpOri,
        mipsPkg::OpLui: begin
          aluSrcImmNext = 1'b1;
          regWriteNext  = 1'b1;
          case (opcode)
            mipsPkg::OpSlti: aluOpNext = mipsPkg::AluSlt;
            mipsPkg::OpAndi: aluOpNext = mipsPkg::AluAnd;
            mipsPkg::OpOri:  aluOpNext = mipsPkg::AluOr;
            mipsPkg::OpLui:  aluOpNext = mipsPkg::AluLui;
            default:         aluOpNext = mipsPkg::AluAdd;
          endcase
        end
        mipsPkg::OpLb, mipsPkg::OpLh, mipsPkg::OpLw, mipsPkg::OpLbu,
        mipsPkg::OpLhu: begin
          aluSrcImmNext   = 1'b1;
          memReadNext     = 1'b1;
          memSizeNext     = accessSize;
          memUnsignedNext = Instr[28];
          regWriteNext    = 1'b1;
          wbSrcNext       = mipsPkg::WbMem;
        end
        mipsPkg::OpSb, mipsPkg::OpSh, mipsPkg::OpSw: begin
          aluSrcImmNext = 1'b1;
          memWriteNext  = 1'b1;
          memSizeNext   = accessSize;
        end
        mipsPkg::OpBeq, mipsPkg::OpBne: begin
          aluOpNext    = mipsPkg::AluSub;
          branchNext   = 1'b1;
          branchNeNext = (opcode == mipsPkg::OpBne);
        end
        mipsPkg::OpJal: begin
          regWriteNext = 1'b1;
          wbSrcNext    = mipsPkg::WbLink;
          writeRegNext = 5'd31;
        end
        default: begin
        end
      endcase
    end
  end

  // decode/execute boundary
  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      AluOp       <= mipsPkg::AluAdd;
      AluSrcImm   <= 1'b0;
      MemRead     <= 1'b0;
      MemWrite    <= 1'b0;
      MemSize     <= mipsPkg::MemWord;
      MemUnsigned <= 1'b0;
      Branch      <= 1'b0;
      BranchNe    <= 1'b0;
      RegWrite    <= 1'b0;
      WbSrc       <= mipsPkg::WbAlu;
      OperandA    <= '0;
      OperandB    <= '0;
      Shamt       <= '0;
      Imm         <= '0;
      StoreData   <= '0;
      PcPlus4Ex   <= '0;
      WriteReg    <= '0;
    end else begin
      AluOp       <= aluOpNext;
      AluSrcImm   <= aluSrcImmNext;
      MemRead     <= memReadNext;
      MemWrite    <= memWriteNext;
      MemSize     <= memSizeNext;
      MemUnsigned <= memUnsignedNext;
      Branch      <= branchNext;
      BranchNe    <= branchNeNext;
      RegWrite    <= regWriteNext;
      WbSrc       <= wbSrcNext;
      OperandA    <= RsValue;
      OperandB    <= RtValue;
      Shamt       <= Instr[10:6];
      Imm         <= immNext;
      StoreData   <= RtValue;
      PcPlus4Ex   <= PcPlus4;
      WriteReg    <= writeRegNext;
    end
  end

endmodule

`default_nettype wire

// ==== dataMemStage.sv ====
`default_nettype none

module dataMemStage (
  input  wire                   Clk,
  input  wire                   MemRead,
  input  wire                   MemWrite,
  input  wire mipsPkg::memSizeT MemSize,
  input  wire                   MemUnsigned,
  input  wire [31:0]            Address,
  input  wire [31:0]            StoreData,
  output logic [31:0]           LoadData
);

  logic [31:0]                         mem [mipsPkg::DataMemWords];
  logic [mipsPkg::DataMemAddrBits-1:0] wordIdx;
  logic [3:0]                          byteEn;
  logic [31:0]                         laneData;
  logic [31:0]                         readWord;
  logic [7:0]                          loadByte;
  logic [15:0]                         loadHalf;

  assign wordIdx = Address[mipsPkg::DataMemAddrBits+1:2];

  initial begin
    for (int i = 0; i < mipsPkg::DataMemWords; i++) begin
      mem[i] = '0;
    end
  end

  // replicate store data so every lane sees it, then enable the right bytes
  always_comb begin
    case (MemSize)
      mipsPkg::MemByte: begin
        byteEn   = 4'b0001 << Address[1:0];
        laneData = {4{StoreData[7:0]}};
      end
      mipsPkg::MemHalf: begin
        byteEn   = Address[1] ? 4'b1100 : 4'b0011;
        laneData = {2{StoreData[15:0]}};
      end
      default: begin
        byteEn   = 4'b1111;
        laneData = StoreData;
      end
    endcase
  end

  always_ff @(posedge Clk) begin
    if (MemWrite) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEn[lane]) begin
          mem[wordIdx][8*lane +: 8] <= laneData[8*lane +: 8];
        end
      end
    end
  end

  // little-endian lane pick for loads
  assign readWord = mem[wordIdx];
  assign loadByte = readWord[{Address[1:0], 3'b000} +: 8];
  assign loadHalf = Address[1] ? readWord[31:16] : readWord[15:0];

  always_comb begin
    LoadData = '0;
    if (MemRead) begin
      case (MemSize)
        mipsPkg::MemByte: LoadData = {{24{!MemUnsigned && loadByte[7]}}, loadByte};
        mipsPkg::MemHalf: LoadData = {{16{!MemUnsigned && loadHalf[15]}}, loadHalf};
        default:          LoadData = readWord;
      endcase
    end
  end

  // misaligned halfword or word accesses are not supported
  accessAligned: assert property (@(posedge Clk) (MemRead || MemWrite) |->
    !((MemSize == mipsPkg::MemHalf && Address[0]) ||
      (MemSize == mipsPkg::MemWord && Address[1:0] != 2'b00)))
    else $error("dataMemStage: misaligned access at %h", Address);

endmodule

`default_nettype wire

// ==== exMemReg.sv ====
`default_nettype none

module exMemReg (
  input  wire                   Clk,
  input  wire                   Reset,
  input  wire [31:0]            AluResultIn,
  input  wire                   ZeroIn,
  input  wire [31:0]            BranchTargetIn,
  input  wire                   BranchTakenIn,
  input  wire [31:0]            StoreDataIn,
  input  wire [31:0]            PcPlus4In,
  input  wire [4:0]             WriteRegIn,
  input  wire                   RegWriteIn,
  input  wire                   MemReadIn,
  input  wire                   MemWriteIn,
  input  wire mipsPkg::memSizeT MemSizeIn,
  input  wire                   MemUnsignedIn,
  input  wire mipsPkg::wbSrcT   WbSrcIn,
  output logic [31:0]           AluResultOut,
  output logic                  ZeroOut,
  output logic [31:0]           BranchTargetOut,
  output logic                  BranchTakenOut,
  output logic [31:0]           StoreDataOut,
  output logic [31:0]           PcPlus4Out,
  output logic [4:0]            WriteRegOut,
  output logic                  RegWriteOut,
  output logic                  MemReadOut,
  output logic                  MemWriteOut,
  output mipsPkg::memSizeT      MemSizeOut,
  output logic                  MemUnsignedOut,
  output mipsPkg::wbSrcT        WbSrcOut
);

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      AluResultOut    <= '0;
      ZeroOut         <= 1'b0;
      BranchTargetOut <= '0;
      BranchTakenOut  <= 1'b0;
      StoreDataOut    <= '0;
      PcPlus4Out      <= '0;
      WriteRegOut     <= '0;
      RegWriteOut     <= 1'b0;
      MemReadOut      <= 1'b0;
      MemWriteOut     <= 1'b0;
      // word access with signed load is the idle setting
      MemSizeOut      <= mipsPkg::MemWord;
      MemUnsignedOut  <= 1'b0;
      WbSrcOut        <= mipsPkg::WbAlu;
    end else begin
      AluResultOut    <= AluResultIn;
      ZeroOut         <= ZeroIn;
      BranchTargetOut <= BranchTargetIn;
      BranchTakenOut  <= BranchTakenIn;
      StoreDataOut    <= StoreDataIn;
      PcPlus4Out      <= PcPlus4In;
      WriteRegOut     <= WriteRegIn;
      RegWriteOut     <= RegWriteIn;
      MemReadOut      <= MemReadIn;
      MemWriteOut     <= MemWriteIn;
      MemSizeOut      <= MemSizeIn;
      MemUnsignedOut  <= MemUnsignedIn;
      WbSrcOut        <= WbSrcIn;
    end
  end

  // decode never issues a load and a store together
  memCtrlExclusive: assert property (@(posedge Clk) disable iff (Reset)
    !(MemReadOut && MemWriteOut))
    else $error("exMemReg: MemRead and MemWrite both high");

endmodule

`default_nettype wire

// ==== memWbResult.sv ====
`default_nettype none

module memWbResult (
  input  wire                 Clk,
  input  wire                 Reset,
  input  wire                 RegWrite,
  input  wire [4:0]           WriteReg,
  input  wire mipsPkg::wbSrcT WbSrc,
  input  wire [31:0]          AluResult,
  input  wire [31:0]          LoadData,
  input  wire [31:0]          PcPlus4,
  output logic                WbRegWrite,
  output logic [4:0]          WbWriteReg,
  output logic [31:0]         WbData
);

  logic [31:0] resultNext;

  always_comb begin
    case (WbSrc)
      mipsPkg::WbMem:  resultNext = LoadData;
      // return address skips the delay slot
      mipsPkg::WbLink: resultNext = PcPlus4 + 32'd4;
      default:         resultNext = AluResult;
    endcase
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      WbRegWrite <= 1'b0;
      WbWriteReg <= '0;
      WbData     <= '0;
    end else begin
      // r0 is hardwired to zero
      WbRegWrite <= RegWrite && (WriteReg != 5'd0);
      WbWriteReg <= WriteReg;
      WbData     <= resultNext;
    end
  end

endmodule

`default_nettype wire

// ==== mipsExMemPath.f ====
mipsPkg.sv
controlDecoder.sv
aluExecute.sv
exMemReg.sv
dataMemStage.sv
memWbResult.sv
mipsExMemPath.sv
tbMipsExMemPath.sv

// ==== mipsExMemPath.sv ====
`default_nettype none

module mipsExMemPath (
  input  wire         Clk,
  input  wire         Reset,
  input  wire         InstrValid,
  input  wire [31:0]  Instr,
  input  wire [31:0]  RsValue,
  input  wire [31:0]  RtValue,
  input  wire [31:0]  PcPlus4,
  output logic        BranchTaken,
  output logic [31:0] BranchTarget,
  output logic        WbRegWrite,
  output logic [4:0]  WbWriteReg,
  output logic [31:0] WbData
);

  // decode/execute register
  mipsPkg::aluOpT   exAluOp;
  mipsPkg::memSizeT exMemSize;
  mipsPkg::wbSrcT   exWbSrc;
  logic             exAluSrcImm;
  logic             exMemRead;
  logic             exMemWrite;
  logic             exMemUnsigned;
  logic             exBranch;
  logic             exBranchNe;
  logic             exRegWrite;
  logic [31:0]      exOperandA;
  logic [31:0]      exOperandB;
  logic [4:0]       exShamt;
  logic [31:0]      exImm;
  logic [31:0]      exStoreData;
  logic [31:0]      exPcPlus4;
  logic [4:0]       exWriteReg;

  // execute results
  logic [31:0]      exAluResult;
  logic             exZero;
  logic [31:0]      exBranchTarget;
  logic             exBranchTaken;

  // memory stage
  mipsPkg::memSizeT memSize;
  mipsPkg::wbSrcT   memWbSrc;
  logic [31:0]      memAluResult;
  logic [31:0]      memStoreData;
  logic [31:0]      memPcPlus4;
  logic [4:0]       memWriteReg;
  logic             memRegWrite;
  logic             memRead;
  logic             memWrite;
  logic             memUnsigned;
  logic [31:0]      memLoadData;

  controlDecoder decode (
    .Clk(Clk), .Reset(Reset), .InstrValid(InstrValid), .Instr(Instr),
    .RsValue(RsValue), .RtValue(RtValue), .PcPlus4(PcPlus4),
    .AluOp(exAluOp), .AluSrcImm(exAluSrcImm), .MemRead(exMemRead),
    .MemWrite(exMemWrite), .MemSize(exMemSize), .MemUnsigned(exMemUnsigned),
    .Branch(exBranch), .BranchNe(exBranchNe), .RegWrite(exRegWrite),
    .WbSrc(exWbSrc), .OperandA(exOperandA), .OperandB(exOperandB),
    .Shamt(exShamt), .Imm(exImm), .StoreData(exStoreData),
    .PcPlus4Ex(exPcPlus4), .WriteReg(exWriteReg)
  );

  aluExecute execute (
    .AluOp(exAluOp), .AluSrcImm(exAluSrcImm), .OperandA(exOperandA),
    .OperandB(exOperandB), .Shamt(exShamt), .Imm(exImm), .PcPlus4Ex(exPcPlus4),
    .Branch(exBranch), .BranchNe(exBranchNe), .AluResult(exAluResult),
    .Zero(exZero), .BranchTarget(exBranchTarget), .BranchTaken(exBranchTaken)
  );

  // ZeroOut has no consumer past this register
  exMemReg exMem (
    .Clk(Clk), .Reset(Reset),
    .AluResultIn(exAluResult), .ZeroIn(exZero), .BranchTargetIn(exBranchTarget),
    .BranchTakenIn(exBranchTaken), .StoreDataIn(exStoreData), .PcPlus4In(exPcPlus4),
    .WriteRegIn(exWriteReg), .RegWriteIn(exRegWrite), .MemReadIn(exMemRead),
    .MemWriteIn(exMemWrite), .MemSizeIn(exMemSize), .MemUnsignedIn(exMemUnsigned),
    .WbSrcIn(exWbSrc),
    .AluResultOut(memAluResult), .ZeroOut(), .BranchTargetOut(BranchTarget),
    .BranchTakenOut(BranchTaken), .StoreDataOut(memStoreData), .PcPlus4Out(memPcPlus4),
    .WriteRegOut(memWriteReg), .RegWriteOut(memRegWrite), .MemReadOut(memRead),
    .MemWriteOut(memWrite), .MemSizeOut(memSize), .MemUnsignedOut(memUnsigned),
    .WbSrcOut(memWbSrc)
  );

  dataMemStage dataMem (
    .Clk(Clk), .MemRead(memRead), .MemWrite(memWrite), .MemSize(memSize),
    .MemUnsigned(memUnsigned), .Address(memAluResult), .StoreData(memStoreData),
    .LoadData(memLoadData)
  );

  memWbResult memWb (
    .Clk(Clk), .Reset(Reset), .RegWrite(memRegWrite), .WriteReg(memWriteReg),
    .WbSrc(memWbSrc), .AluResult(memAluResult), .LoadData(memLoadData),
    .PcPlus4(memPcPlus4), .WbRegWrite(WbRegWrite), .WbWriteReg(WbWriteReg),
    .WbData(WbData)
  );

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

  // major opcodes handled by this core
  typedef enum logic [5:0] {
    OpSpecial = 6'h00,
    OpJal     = 6'h03,
    OpBeq     = 6'h04,
    OpBne     = 6'h05,
    OpAddiu   = 6'h09,
    OpSlti    = 6'h0a,
    OpAndi    = 6'h0c,
    OpOri     = 6'h0d,
    OpLui     = 6'h0f,
    OpLb      = 6'h20,
    OpLh      = 6'h21,
    OpLw      = 6'h23,
    OpLbu     = 6'h24,
    OpLhu     = 6'h25,
    OpSb      = 6'h28,
    OpSh      = 6'h29,
    OpSw      = 6'h2b
  } opcodeT;

  // SPECIAL function field
  typedef enum logic [5:0] {
    FnSll  = 6'h00,
    FnSrl  = 6'h02,
    FnAddu = 6'h21,
    FnSubu = 6'h23,
    FnAnd  = 6'h24,
    FnOr   = 6'h25,
    FnXor  = 6'h26,
    FnSlt  = 6'h2a,
    FnSltu = 6'h2b
  } functT;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluSltu,
    AluSll,
    AluSrl,
    AluLui
  } aluOpT;

  typedef enum logic [1:0] {
    MemByte = 2'd0,
    MemHalf = 2'd1,
    MemWord = 2'd2
  } memSizeT;

  // link writes PC+4 plus 4
  typedef enum logic [1:0] {
    WbAlu  = 2'd0,
    WbMem  = 2'd1,
    WbLink = 2'd2
  } wbSrcT;

  localparam int DataMemWords    = 256;
  localparam int DataMemAddrBits = $clog2(DataMemWords);

endpackage

`default_nettype wire

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module tbMipsExMemPath \
  -f mipsExMemPath.f -Mdir "$buildDir" -o simTb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$buildDir/simTb" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$logFile"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== tbMipsExMemPath.sv ====
`default_nettype none

module tbMipsExMemPath;

  localparam int ClkPeriod = 4;
  // reset, then each test's issues plus its two drain bubbles
  localparam int IssueCycles  = 2 + 4 + (40 + 2) + (8 + 2) + (4 + 2) + (1 + 2) + (3 + 2);
  localparam int MarginCycles = 40;

  logic        Clk;
  logic        Reset;
  logic        InstrValid;
  logic [31:0] Instr;
  logic [31:0] RsValue;
  logic [31:0] RtValue;
  logic [31:0] PcPlus4;
  logic        BranchTaken;
  logic [31:0] BranchTarget;
  logic        WbRegWrite;
  logic [4:0]  WbWriteReg;
  logic [31:0] WbData;

  int          errorCount;
  int          cycleCount;
  logic [31:0] rngState;
  logic [7:0]  tbMem [mipsPkg::DataMemWords * 4];

  // expectations indexed by age in sampling edges
  logic        expWrite  [3];
  logic [4:0]  expReg    [3];
  logic [31:0] expData   [3];
  logic        expBranch [3];
  logic        expTaken  [3];
  logic [31:0] expTarget [3];

  mipsExMemPath UUT (
    .Clk(Clk), .Reset(Reset), .InstrValid(InstrValid), .Instr(Instr),
    .RsValue(RsValue), .RtValue(RtValue), .PcPlus4(PcPlus4),
    .BranchTaken(BranchTaken), .BranchTarget(BranchTarget),
    .WbRegWrite(WbRegWrite), .WbWriteReg(WbWriteReg), .WbData(WbData)
  );

  always #(ClkPeriod / 2) Clk = ~Clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // architectural result of one instruction from standard MIPS encodings
  function automatic void modelInstr(input logic [31:0] instr, input logic [31:0] rs,
                                     input logic [31:0] rt, input logic [31:0] pc4,
                                     output logic write, output logic [4:0] dest,
                                     output logic [31:0] data, output logic isBranch,
                                     output logic taken, output logic [31:0] target);
    logic [31:0] sext;
    logic [31:0] addr;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    sext = {{16{instr[15]}}, instr[15:0]};
    addr = rs + sext;
    b = tbMem[addr[9:0]];
    h = {tbMem[{addr[9:1], 1'b1}], tbMem[{addr[9:1], 1'b0}]};
    w = {tbMem[{addr[9:2], 2'd3}], tbMem[{addr[9:2], 2'd2}],
         tbMem[{addr[9:2], 2'd1}], tbMem[{addr[9:2], 2'd0}]};
    write = 1'b1;
    dest = instr[20:16];
    data = 32'h0;
    isBranch = 1'b0;
    taken = 1'b0;
    target = pc4 + {sext[29:0], 2'b00};
    case (instr[31:26])
      6'h00: begin
        dest = instr[15:11];
        case (instr[5:0])
          6'h21: data = rs + rt;
          6'h23: data = rs - rt;
          6'h24: data = rs & rt;
          6'h25: data = rs | rt;
          6'h26: data = rs ^ rt;
          6'h2a: data = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
          6'h2b: data = (rs < rt) ? 32'd1 : 32'd0;
          6'h00: data = rt << instr[10:6];
          6'h02: data = rt >> instr[10:6];
          default: write = 1'b0;
        endcase
      end
      6'h09: data = addr;
      6'h0a: data = ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
      6'h0c: data = rs & {16'h0000, instr[15:0]};
      6'h0d: data = rs | {16'h0000, instr[15:0]};
      6'h0f: data = {instr[15:0], 16'h0000};
      6'h20: data = {{24{b[7]}}, b};
      6'h21: data = {{16{h[15]}}, h};
      6'h23: data = w;
      6'h24: data = {24'h0, b};
      6'h25: data = {16'h0, h};
      6'h04, 6'h05: begin
        write = 1'b0;
        isBranch = 1'b1;
        taken = (rs == rt) ^ instr[26];
      end
      6'h03: begin
        dest = 5'd31;
        data = pc4 + 32'd4;
      end
      default: write = 1'b0;
    endcase
    // register 0 never takes a write
    write = write && (dest != 5'd0);
  endfunction

  function automatic void updateMem(input logic [31:0] instr, input logic [31:0] rs,
                                    input logic [31:0] rt);
    logic [31:0] addr;
    addr = rs + {{16{instr[15]}}, instr[15:0]};
    case (instr[31:26])
      6'h28: tbMem[addr[9:0]] = rt[7:0];
      6'h29: begin
        tbMem[{addr[9:1], 1'b0}] = rt[7:0];
        tbMem[{addr[9:1], 1'b1}] = rt[15:8];
      end
      6'h2b: begin
        for (int k = 0; k < 4; k++) begin
          tbMem[{addr[9:2], 2'(k)}] = rt[8*k +: 8];
        end
      end
      default: begin
      end
    endcase
  endfunction

  task automatic checkOutputs();
    cycleCount++;
    if (BranchTaken !== expTaken[1]) begin
      errorCount++;
      $display("FAILED BranchTaken expected %h actual %h", expTaken[1], BranchTaken);
    end
    if (expBranch[1] && BranchTarget !== expTarget[1]) begin
      errorCount++;
      $display("FAILED BranchTarget expected %h actual %h", expTarget[1], BranchTarget);
    end
    if (WbRegWrite !== expWrite[2]) begin
      errorCount++;
      $display("FAILED WbRegWrite expected %h actual %h", expWrite[2], WbRegWrite);
    end
    if (expWrite[2] && WbWriteReg !== expReg[2]) begin
      errorCount++;
      $display("FAILED WbWriteReg expected %h actual %h", expReg[2], WbWriteReg);
    end
    if (expWrite[2] && WbData !== expData[2]) begin
      errorCount++;
      $display("FAILED WbData expected %h actual %h", expData[2], WbData);
    end
  endtask

  // drive one slot, wait for its sampling edge, then check older slots
  task automatic issue(input logic valid, input logic [31:0] instr, input logic [31:0] rs,
                       input logic [31:0] rt, input logic [31:0] pc4);
    logic        wr;
    logic [4:0]  dst;
    logic [31:0] dat;
    logic        br;
    logic        tk;
    logic [31:0] tgt;
    modelInstr(instr, rs, rt, pc4, wr, dst, dat, br, tk, tgt);
    if (valid) begin
      updateMem(instr, rs, rt);
    end else begin
      wr = 1'b0;
      br = 1'b0;
      tk = 1'b0;
    end
    InstrValid = valid;
    Instr = instr;
    RsValue = rs;
    RtValue = rt;
    PcPlus4 = pc4;
    @(posedge Clk);
    #1;
    for (int i = 2; i > 0; i--) begin
      expWrite[i] = expWrite[i-1];
      expReg[i] = expReg[i-1];
      expData[i] = expData[i-1];
      expBranch[i] = expBranch[i-1];
      expTaken[i] = expTaken[i-1];
      expTarget[i] = expTarget[i-1];
    end
    expWrite[0] = wr;
    expReg[0] = dst;
    expData[0] = dat;
    expBranch[0] = br;
    expTaken[0] = tk;
    expTarget[0] = tgt;
    checkOutputs();
  endtask

  task automatic drain();
    repeat (2) issue(1'b0, 32'h0, 32'h0, 32'h0, 32'h0);
  endtask

  task automatic resetAndBubbles();
    if (WbRegWrite !== 1'b0) begin
      errorCount++;
      $display("FAILED WbRegWrite expected %h actual %h", 1'b0, WbRegWrite);
    end
    if (BranchTaken !== 1'b0) begin
      errorCount++;
      $display("FAILED BranchTaken expected %h actual %h", 1'b0, BranchTaken);
    end
    // garbage instruction words must not leak through
    repeat (4) issue(1'b0, nextRandom(), nextRandom(), nextRandom(), nextRandom());
  endtask

  task automatic aluMix();
    logic [31:0] r;
    logic [31:0] instr;
    logic [4:0]  rtN;
    logic [4:0]  rdN;
    int          kind;
    for (int i = 0; i < 40; i++) begin
      r = nextRandom();
      rtN = r[9:5];
      rdN = r[14:10];
      if (i % 8 == 3) begin
        rtN = 5'd0;
        rdN = 5'd0;
      end
      // cycle through all thirteen operations
      kind = i % 13;
      case (kind)
        0: instr = rType(mipsPkg::FnAddu, r[4:0], rtN, rdN, r[19:15]);
        1: instr = rType(mipsPkg::FnSubu, r[4:0], rtN, rdN, r[19:15]);
        2: instr = rType(mipsPkg::FnAnd, r[4:0], rtN, rdN, r[19:15]);
        3: instr = rType(mipsPkg::FnOr, r[4:0], rtN, rdN, r[19:15]);
        4: instr = rType(mipsPkg::FnXor, r[4:0], rtN, rdN, r[19:15]);
        5: instr = rType(mipsPkg::FnSlt, r[4:0], rtN, rdN, r[19:15]);
        6: instr = rType(mipsPkg::FnSltu, r[4:0], rtN, rdN, r[19:15]);
        7: instr = rType(mipsPkg::FnSll, r[4:0], rtN, rdN, r[19:15]);
        8: instr = rType(mipsPkg::FnSrl, r[4:0], rtN, rdN, r[19:15]);
        9: instr = iType(mipsPkg::OpAddiu, r[4:0], rtN, r[31:16]);
        10: instr = iType(mipsPkg::OpAndi, r[4:0], rtN, r[31:16]);
        11: instr = iType(mipsPkg::OpOri, r[4:0], rtN, r[31:16]);
        default: instr = iType(mipsPkg::OpLui, r[4:0], rtN, r[31:16]);
      endcase
      issue(1'b1, instr, nextRandom(), nextRandom(), 32'h0040_0000 + 32'(4 * i));
    end
    drain();
  endtask

  task automatic sizedLoadStore();
    // word 0x140 ends up as 7e5a_f3bb
    issue(1'b1, iType(mipsPkg::OpSw, 5'd4, 5'd5, 16'h0040), 32'h100, 32'h8899_aabb, 32'h0);
    issue(1'b1, iType(mipsPkg::OpSb, 5'd4, 5'd6, 16'hffc1), 32'h180, 32'h5566_77f3, 32'h0);
    issue(1'b1, iType(mipsPkg::OpSh, 5'd4, 5'd7, 16'h0002), 32'h140, 32'h1234_7e5a, 32'h0);
    issue(1'b1, iType(mipsPkg::OpLw, 5'd4, 5'd8, 16'h0000), 32'h140, 32'h0, 32'h0);
    issue(1'b1, iType(mipsPkg::OpLh, 5'd4, 5'd9, 16'h0000), 32'h140, 32'h0, 32'h0);
    issue(1'b1, iType(mipsPkg::OpLhu, 5'd4, 5'd10, 16'h0000), 32'h140, 32'h0, 32'h0);
    issue(1'b1, iType(mipsPkg::OpLb, 5'd4, 5'd11, 16'h0001), 32'h140, 32'h0, 32'h0);
    issue(1'b1, iType(mipsPkg::OpLbu, 5'd4, 5'd12, 16'hfffb), 32'h148, 32'h0, 32'h0);
    drain();
  endtask

  task automatic branchCheck();
    logic [31:0] a;
    a = nextRandom();
    issue(1'b1, iType(mipsPkg::OpBeq, 5'd1, 5'd2, 16'h0010), a, a, 32'h0040_1004);
    issue(1'b1, iType(mipsPkg::OpBeq, 5'd1, 5'd2, 16'h0010), a, a ^ 32'h100, 32'h0040_1008);
    issue(1'b1, iType(mipsPkg::OpBne, 5'd1, 5'd2, 16'hfff8), a, a, 32'h0040_100c);
    issue(1'b1, iType(mipsPkg::OpBne, 5'd1, 5'd2, 16'hfff8), a, ~a, 32'h0040_1010);
    drain();
  endtask

  task automatic jumpLink();
    issue(1'b1, {mipsPkg::OpJal, 26'h010_0234}, nextRandom(), nextRandom(), 32'h0040_2010);
    drain();
  endtask

  task automatic pipelineOverlap();
    logic [31:0] base;
    base = nextRandom() & 32'h0000_03fc;
    issue(1'b1, iType(mipsPkg::OpSw, 5'd3, 5'd4, 16'h0000), base, nextRandom(), 32'h0);
    // load right behind the store must see it
    issue(1'b1, iType(mipsPkg::OpLw, 5'd3, 5'd9, 16'h0000), base, 32'h0, 32'h0);
    issue(1'b1, rType(mipsPkg::FnAddu, 5'd1, 5'd2, 5'd10, 5'd0), nextRandom(), nextRandom(),
          32'h0);
    drain();
  endtask

  initial begin
    #((IssueCycles + MarginCycles) * ClkPeriod);
    $display("timeout: the tests did not finish in the expected time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    Clk = 1'b0;
    Reset = 1'b1;
    InstrValid = 1'b0;
    Instr = 32'h0;
    RsValue = 32'h0;
    RtValue = 32'h0;
    PcPlus4 = 32'h0;
    errorCount = 0;
    cycleCount = 0;
    rngState = 32'h432b_2551;
    for (int i = 0; i < mipsPkg::DataMemWords * 4; i++) begin
      tbMem[i] = 8'h00;
    end
    for (int i = 0; i < 3; i++) begin
      expWrite[i] = 1'b0;
      expReg[i] = 5'd0;
      expData[i] = 32'h0;
      expBranch[i] = 1'b0;
      expTaken[i] = 1'b0;
      expTarget[i] = 32'h0;
    end
    repeat (2) @(posedge Clk);
    #1;
    Reset = 1'b0;
    resetAndBubbles();
    aluMix();
    sizedLoadStore();
    branchCheck();
    jumpLink();
    pipelineOverlap();
    $display("summary: %0d cycles checked, %0d errors", cycleCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
